// File: video_pkg.sv
`default_nettype none

package video_pkg;

  typedef logic [7:0]  pix_t;    // one colour component
  typedef logic [10:0] coord_t;  // pixel or line count

  // one pixel slot as it travels down the video path
  typedef struct packed {
    pix_t r;
    pix_t g;
    pix_t b;
    logic hsync;  // active high
    logic vsync;  // active high
    logic blank;
  } video_t;

  // character cell size
  localparam int GLYPH_W = 8;
  localparam int GLYPH_H = 8;

endpackage

`default_nettype wire

// File: spi_pkg.sv
`default_nettype none

package spi_pkg;

  typedef logic [31:0] spi_addr_t;
  typedef logic [7:0]  spi_data_t;

  typedef struct packed {
    logic      wr;       // one-cycle strobe
    logic      rd;       // one-cycle strobe
    spi_addr_t addr;
    spi_data_t wr_data;
  } spi_bus_t;

  // addr[31:24] selects the target
  localparam logic [7:0] REGION_RAM   = 8'h00;
  localparam logic [7:0] REGION_CHARS = 8'hF0;
  localparam logic [7:0] REGION_CTRL  = 8'hF1;

  localparam spi_data_t CMD_WRITE = 8'h00;
  localparam spi_data_t CMD_READ  = 8'h01;

endpackage

`default_nettype wire

// File: spi_ram_slave.sv
`timescale 1ns/1ns
`default_nettype none

module spi_ram_slave
  import spi_pkg::*;
(
  input  wire            clk_cpu,
  input  wire            i_rst_n,
  input  wire            i_csn,
  input  wire            i_sclk,
  input  wire            i_mosi,
  input  wire spi_data_t i_rd_data,
  output logic           o_miso,
  output spi_bus_t       o_bus
);

  typedef enum logic [2:0] {IDLE, CMD, ADDR, DUMMY, DATA} phase_t;

  logic [1:0] csn_sync;
  logic [2:0] sclk_sync;   // extra stage for edge detect
  logic [1:0] mosi_sync;
  logic       csn_s;
  logic       mosi_s;
  logic       sclk_rise;
  logic       sclk_fall;
  phase_t     phase;
  logic [2:0] bit_cnt;
  logic [1:0] addr_cnt;    // address bytes seen
  logic       is_read;
  logic       is_write;
  spi_data_t  shift_in;
  spi_data_t  rx_byte;
  spi_data_t  rd_buf;
  spi_data_t  shift_out;
  logic       rd_q;
  logic       load_out;    // next falling edge starts a read byte
  spi_bus_t   bus_q;

  assign csn_s     = csn_sync[1];
  assign mosi_s    = mosi_sync[1];
  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign rx_byte   = {shift_in[6:0], mosi_s};
  assign o_bus     = bus_q;
  assign o_miso    = shift_out[7];  // MSB first

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      csn_sync  <= '1;
      sclk_sync <= '0;
    end
    else
    begin
      csn_sync  <= {csn_sync[0], i_csn};
      sclk_sync <= {sclk_sync[1:0], i_sclk};
    end
  end

  always_ff @(posedge clk_cpu)
    mosi_sync <= {mosi_sync[0], i_mosi};

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      phase    <= IDLE;
      bit_cnt  <= '0;
      addr_cnt <= '0;
      is_read  <= 1'b0;
      is_write <= 1'b0;
      bus_q    <= '0;
    end
    else
    begin
      bus_q.wr <= 1'b0;
      bus_q.rd <= 1'b0;
      if (bus_q.wr)
        bus_q.addr <= bus_q.addr + 1'b1;  // step once the write has landed
      if (csn_s)
      begin
        phase   <= IDLE;  // abort drops the partial byte
        bit_cnt <= '0;
      end
      else if (phase == IDLE)
        phase <= CMD;
      else if (sclk_rise)
      begin
        shift_in <= rx_byte;
        bit_cnt  <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7)
        begin
          case (phase)
            CMD:
            begin
              is_read  <= (rx_byte == CMD_READ);
              is_write <= (rx_byte == CMD_WRITE);
              addr_cnt <= '0;
              phase    <= ADDR;
            end
            ADDR:
            begin
              bus_q.addr <= {bus_q.addr[23:0], rx_byte};
              addr_cnt   <= addr_cnt + 1'b1;
              if (addr_cnt == 2'd3)
              begin
                phase    <= is_read ? DUMMY : DATA;
                bus_q.rd <= is_read;  // prefetch first read byte
              end
            end
            DUMMY:
              phase <= DATA;
            DATA:
            begin
              if (is_write)
              begin
                bus_q.wr      <= 1'b1;
                bus_q.wr_data <= rx_byte;
              end
              if (is_read)
              begin
                bus_q.addr <= bus_q.addr + 1'b1;
                bus_q.rd   <= 1'b1;
              end
            end
            default: ;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk_cpu)
    if (rd_q)
      rd_buf <= i_rd_data;  // ram answers one cycle after rd

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      rd_q      <= 1'b0;
      load_out  <= 1'b0;
      shift_out <= '0;
    end
    else
    begin
      rd_q <= bus_q.rd;
      if (csn_s)
        load_out <= 1'b0;
      else if (sclk_rise && bit_cnt == 3'd7 &&
               (phase == DUMMY || (phase == DATA && is_read)))
        load_out <= 1'b1;
      else if (sclk_fall && load_out)
        load_out <= 1'b0;
      if (sclk_fall)
      begin
        if (load_out && !csn_s)
          shift_out <= rd_buf;
        else
          shift_out <= {shift_out[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: scratch_ram.sv
`timescale 1ns/1ns
`default_nettype none

module scratch_ram
  import spi_pkg::*;
(
  input  wire           clk_cpu,
  input  wire spi_bus_t i_bus,
  output spi_data_t     o_rd_data
);

  spi_data_t mem [16];

  // only the low nibble decodes so other regions alias on read
  always_ff @(posedge clk_cpu)
  begin
    if (i_bus.wr && i_bus.addr[31:24] == REGION_RAM)
      mem[i_bus.addr[3:0]] <= i_bus.wr_data;
    if (i_bus.rd)
      o_rd_data <= mem[i_bus.addr[3:0]];
  end

endmodule

`default_nettype wire

// File: vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing
  import video_pkg::*;
#(
  parameter int H_ACTIVE = 64,
  parameter int H_FRONT  = 4,
  parameter int H_PULSE  = 8,
  parameter int H_BACK   = 8,
  parameter int V_ACTIVE = 32,
  parameter int V_FRONT  = 2,
  parameter int V_PULSE  = 2,
  parameter int V_BACK   = 4
)
(
  input  wire    clk_cpu,
  input  wire    i_rst_n,
  output video_t o_video
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_PULSE + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_PULSE + V_BACK;
  localparam int H_SYNC  = H_ACTIVE + H_FRONT;  // first hsync pixel
  localparam int V_SYNC  = V_ACTIVE + V_FRONT;

  coord_t h_cnt;
  coord_t v_cnt;
  logic   active;

  assign active = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (h_cnt == coord_t'(H_TOTAL - 1))
    begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == coord_t'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
    end
    else
      h_cnt <= h_cnt + 1'b1;
  end

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      o_video       <= '0;
      o_video.blank <= 1'b1;
    end
    else
    begin
      o_video.hsync <= (h_cnt >= H_SYNC) && (h_cnt < H_SYNC + H_PULSE);
      o_video.vsync <= (v_cnt >= V_SYNC) && (v_cnt < V_SYNC + V_PULSE);
      o_video.blank <= !active;
      o_video.r     <= active ? pix_t'(h_cnt) : '0;  // test picture
      o_video.g     <= active ? pix_t'(v_cnt) : '0;
      o_video.b     <= active ? pix_t'(h_cnt ^ v_cnt) : '0;
    end
  end

endmodule

`default_nettype wire

// File: osd_overlay.sv
`timescale 1ns/1ns
`default_nettype none

module osd_overlay
  import video_pkg::*;
  import spi_pkg::*;
#(
  parameter int OSD_X    = 16,
  parameter int OSD_Y    = 8,
  parameter int OSD_COLS = 4,
  parameter int OSD_ROWS = 2
)
(
  input  wire           clk_cpu,
  input  wire           i_rst_n,
  input  wire spi_bus_t i_bus,
  input  wire video_t   i_video,
  output video_t        o_video
);

  localparam int N_CHARS = OSD_COLS * OSD_ROWS;
  localparam int CA_W    = $clog2(N_CHARS);
  localparam int GB_W    = $clog2(GLYPH_W);
  localparam int GR_W    = $clog2(GLYPH_H);
  localparam int X_END   = OSD_X + OSD_COLS * GLYPH_W;
  localparam int Y_END   = OSD_Y + OSD_ROWS * GLYPH_H;

  logic [1:0]         chars [N_CHARS];    // glyph index per cell
  logic [GLYPH_W-1:0] font [4 * GLYPH_H];
  logic               osd_en;
  coord_t             x_cnt;
  coord_t             y_cnt;
  coord_t             dx;
  coord_t             dy;
  coord_t             char_idx;
  logic               blank_d;
  logic               in_win;
  video_t             s1_video;
  logic               s1_win;
  logic [1:0]         s1_glyph;
  logic [GR_W-1:0]    s1_row;
  logic [GB_W-1:0]    s1_col;
  logic [GLYPH_W-1:0] glyph_row;
  logic               pix_on;

  initial
    $readmemh("font.mem", font);

  assign dx       = x_cnt - coord_t'(OSD_X);
  assign dy       = y_cnt - coord_t'(OSD_Y);
  assign char_idx = coord_t'((dy / GLYPH_H) * OSD_COLS + dx / GLYPH_W);
  assign in_win   = !i_video.blank && x_cnt >= OSD_X && x_cnt < X_END &&
                    y_cnt >= OSD_Y && y_cnt < Y_END;

  // own pixel position rebuilt from blank and vsync
  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      x_cnt   <= '0;
      y_cnt   <= '0;
      blank_d <= 1'b1;
    end
    else
    begin
      blank_d <= i_video.blank;
      x_cnt   <= i_video.blank ? '0 : x_cnt + 1'b1;
      if (i_video.vsync)
        y_cnt <= '0;
      else if (i_video.blank && !blank_d)
        y_cnt <= y_cnt + 1'b1;  // end of an active line
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      osd_en <= 1'b1;
      for (int i = 0; i < N_CHARS; i++)
        chars[i] <= '0;
    end
    else if (i_bus.wr)
    begin
      if (i_bus.addr[31:24] == REGION_CTRL)
        osd_en <= i_bus.wr_data[0];
      if (i_bus.addr[31:24] == REGION_CHARS && i_bus.addr[23:0] < N_CHARS)
        chars[i_bus.addr[CA_W-1:0]] <= i_bus.wr_data[1:0];
    end
  end

  // stage 1 reads the character memory
  always_ff @(posedge clk_cpu)
  begin
    s1_video <= i_video;
    s1_win   <= in_win && osd_en;
    s1_glyph <= chars[char_idx[CA_W-1:0]];
    s1_row   <= dy[GR_W-1:0];
    s1_col   <= dx[GB_W-1:0];
  end

  assign glyph_row = font[{s1_glyph, s1_row}];
  assign pix_on    = glyph_row[GLYPH_W - 1 - s1_col];  // bit 7 is leftmost

  // stage 2 does the font lookup and mix
  always_ff @(posedge clk_cpu)
  begin
    o_video <= s1_video;
    if (s1_win)
    begin
      o_video.r <= pix_on ? pix_t'('1) : s1_video.r >> 1;
      o_video.g <= pix_on ? pix_t'('1) : s1_video.g >> 1;
      o_video.b <= pix_on ? pix_t'('1) : s1_video.b >> 1;  // half intensity
    end
  end

endmodule

`default_nettype wire

// File: osd_top.sv
`timescale 1ns/1ns
`default_nettype none

module osd_top
  import video_pkg::*;
  import spi_pkg::*;
#(
  parameter int H_ACTIVE = 64,
  parameter int H_FRONT  = 4,
  parameter int H_PULSE  = 8,
  parameter int H_BACK   = 8,
  parameter int V_ACTIVE = 32,
  parameter int V_FRONT  = 2,
  parameter int V_PULSE  = 2,
  parameter int V_BACK   = 4,
  parameter int OSD_X    = 16,
  parameter int OSD_Y    = 8,
  parameter int OSD_COLS = 4,
  parameter int OSD_ROWS = 2
)
(
  input  wire    clk_cpu,
  input  wire    i_rst_n,
  input  wire    i_csn,
  input  wire    i_sclk,
  input  wire    i_mosi,
  output logic   o_miso,
  output video_t o_video
);

  spi_bus_t  bus;          // shared by ram and overlay
  spi_data_t ram_rd_data;
  video_t    raw_video;    // test picture before the overlay

  spi_ram_slave u_slave (
    .clk_cpu   (clk_cpu),
    .i_rst_n   (i_rst_n),
    .i_csn     (i_csn),
    .i_sclk    (i_sclk),
    .i_mosi    (i_mosi),
    .i_rd_data (ram_rd_data),
    .o_miso    (o_miso),
    .o_bus     (bus)
  );

  scratch_ram u_ram (
    .clk_cpu   (clk_cpu),
    .i_bus     (bus),
    .o_rd_data (ram_rd_data)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_PULSE  (H_PULSE),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_PULSE  (V_PULSE),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk_cpu (clk_cpu),
    .i_rst_n (i_rst_n),
    .o_video (raw_video)
  );

  osd_overlay #(
    .OSD_X    (OSD_X),
    .OSD_Y    (OSD_Y),
    .OSD_COLS (OSD_COLS),
    .OSD_ROWS (OSD_ROWS)
  ) u_overlay (
    .clk_cpu (clk_cpu),
    .i_rst_n (i_rst_n),
    .i_bus   (bus),
    .i_video (raw_video),
    .o_video (o_video)
  );

endmodule

`default_nettype wire

// File: osd_checker.sv
`timescale 1ns/1ns
`default_nettype none

module osd_checker
  import video_pkg::*;
  import spi_pkg::*;
#(
  parameter int H_PULSE = 8
)
(
  input wire            clk_cpu,
  input wire            i_rst_n,
  input wire video_t    i_video,
  input wire spi_bus_t  i_bus,
  input wire spi_data_t i_rd_data
);

  coord_t    hs_len;       // cycles of hsync so far
  spi_data_t shadow [16];  // what the ram should hold
  int        fail_cnt = 0;

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
      hs_len <= '0;
    else if (i_video.hsync)
      hs_len <= hs_len + 1'b1;
    else
      hs_len <= '0;
  end

  always_ff @(posedge clk_cpu)
    if (i_bus.wr && i_bus.addr[31:24] == REGION_RAM)
      shadow[i_bus.addr[3:0]] <= i_bus.wr_data;

  a_hsync_width: assert property (@(posedge clk_cpu) disable iff (!i_rst_n)
    $fell(i_video.hsync) |-> hs_len == coord_t'(H_PULSE))
  else
  begin
    $error("hsync pulse length differs from H_PULSE");
    fail_cnt++;
  end

  a_sync_in_blank: assert property (@(posedge clk_cpu) disable iff (!i_rst_n)
    (i_video.hsync || i_video.vsync) |-> i_video.blank)
  else
  begin
    $error("sync active outside blank");
    fail_cnt++;
  end

  a_wr_rd_apart: assert property (@(posedge clk_cpu) disable iff (!i_rst_n)
    !(i_bus.wr && i_bus.rd))
  else
  begin
    $error("wr and rd strobes high together");
    fail_cnt++;
  end

  // ram answers one cycle after rd
  a_rd_data: assert property (@(posedge clk_cpu) disable iff (!i_rst_n)
    i_bus.rd |=> i_rd_data == $past(shadow[i_bus.addr[3:0]]))
  else
  begin
    $error("read data does not match the last write");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// File: tb_osd_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_osd_top
  import video_pkg::*;
  import spi_pkg::*;
();

  localparam int H_ACTIVE = 64;
  localparam int H_PULSE  = 8;
  localparam int H_TOTAL  = 64 + 4 + 8 + 8;
  localparam int V_ACTIVE = 32;
  localparam int V_PULSE  = 2;
  localparam int V_TOTAL  = 32 + 2 + 2 + 4;
  localparam int OSD_X    = 16;
  localparam int OSD_Y    = 8;
  localparam int OSD_COLS = 4;
  localparam int OSD_ROWS = 2;
  localparam int N_CHARS  = OSD_COLS * OSD_ROWS;
  localparam int SPI_HALF = 10;  // clk_cpu cycles per sck half-period
  localparam int BYTE_NS  = 16 * SPI_HALF * 4;
  localparam int FRAME_NS = H_TOTAL * V_TOTAL * 4;
  localparam int TIMEOUT_NS = 2 * (12 * FRAME_NS + 150 * BYTE_NS);

  logic   clk_cpu = 1'b0;
  logic   i_rst_n;
  logic   i_csn;
  logic   i_sclk;
  logic   i_mosi;
  wire    o_miso;
  video_t o_video;

  logic [7:0] ram_shadow [16];
  logic [7:0] char_shadow [N_CHARS];
  logic       en_shadow;
  logic [7:0] font_rom [4 * GLYPH_H];
  logic [7:0] xfer_buf [16];
  logic [7:0] lfsr;
  logic       pix_check;
  int errors = 0;
  int tests_failed = 0;
  int frame_cnt = 0;
  int set_hits = 0;
  int x_pos, y_pos, cyc, h_rise_t, v_rise_t;
  logic h_seen, v_seen, prev_blank, prev_hs, prev_vs;

  osd_top dut (
    .clk_cpu (clk_cpu),
    .i_rst_n (i_rst_n),
    .i_csn   (i_csn),
    .i_sclk  (i_sclk),
    .i_mosi  (i_mosi),
    .o_miso  (o_miso),
    .o_video (o_video)
  );

  bind osd_top osd_checker #(.H_PULSE(H_PULSE)) u_checker (
    .clk_cpu   (clk_cpu),
    .i_rst_n   (i_rst_n),
    .i_video   (o_video),
    .i_bus     (bus),
    .i_rd_data (ram_rd_data)
  );

  always #2 clk_cpu = ~clk_cpu;

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};  // one step per bit
    end
  endtask

  task automatic report_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %s got 0x%h expected 0x%h", what, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name, input int base);
    if (errors == base)
      $display("test %-24s ok", name);
    else
    begin
      $display("test %-24s failed with %0d errors", name, errors - base);
      tests_failed++;
    end
  endtask

  // test picture with the overlay rule on top
  function automatic logic [23:0] expect_rgb(input int x, input int y);
    logic [7:0] r, g, b, row;
    int cx, cy, code;
    r = 8'(x);
    g = 8'(y);
    b = r ^ g;
    if (!en_shadow || x < OSD_X || x >= OSD_X + OSD_COLS * GLYPH_W ||
        y < OSD_Y || y >= OSD_Y + OSD_ROWS * GLYPH_H)
      return {r, g, b};
    cx = x - OSD_X;
    cy = y - OSD_Y;
    code = int'(char_shadow[(cy / GLYPH_H) * OSD_COLS + cx / GLYPH_W][1:0]);
    row = font_rom[code * GLYPH_H + cy % GLYPH_H];
    if (row[GLYPH_W - 1 - cx % GLYPH_W])
      return 24'hFFFFFF;
    return {r >> 1, g >> 1, b >> 1};
  endfunction

  // video monitor samples o_video away from the rising edge
  always @(negedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      x_pos = 0;
      y_pos = 0;
      cyc = 0;
      h_seen = 0;
      v_seen = 0;
      prev_blank = 1;
      prev_hs = 0;
      prev_vs = 0;
    end
    else
    begin
      cyc++;
      if (o_video.hsync && !prev_hs)
      begin
        if (h_seen)
          assert (cyc - h_rise_t == H_TOTAL)
          else report_value("o_video.hsync period", cyc - h_rise_t, H_TOTAL);
        h_rise_t = cyc;
        h_seen = 1;
      end
      if (!o_video.hsync && prev_hs)
        assert (cyc - h_rise_t == H_PULSE)
        else report_value("o_video.hsync width", cyc - h_rise_t, H_PULSE);
      if (o_video.vsync && !prev_vs)
      begin
        if (v_seen)
          assert (cyc - v_rise_t == H_TOTAL * V_TOTAL)
          else report_value("o_video.vsync period", cyc - v_rise_t, H_TOTAL * V_TOTAL);
        assert (y_pos == V_ACTIVE)
        else report_value("active lines per frame", y_pos, V_ACTIVE);
        v_rise_t = cyc;
        v_seen = 1;
        y_pos = 0;
        frame_cnt++;
      end
      if (!o_video.vsync && prev_vs)
        assert (cyc - v_rise_t == V_PULSE * H_TOTAL)
        else report_value("o_video.vsync width", cyc - v_rise_t, V_PULSE * H_TOTAL);
      if (o_video.blank)
        assert ({o_video.r, o_video.g, o_video.b} == 24'h0)
        else report_value("o_video rgb in blank", {o_video.r, o_video.g, o_video.b}, 0);
      if (!o_video.blank)
      begin
        if (pix_check)
        begin
          if ({o_video.r, o_video.g, o_video.b} == 24'hFFFFFF)
            set_hits++;  // lit text pixel on screen
          assert ({o_video.r, o_video.g, o_video.b} == expect_rgb(x_pos, y_pos))
          else report_value($sformatf("o_video rgb at x=%0d y=%0d", x_pos, y_pos),
                            {o_video.r, o_video.g, o_video.b}, expect_rgb(x_pos, y_pos));
        end
        x_pos++;
      end
      else if (!prev_blank)
      begin
        assert (x_pos == H_ACTIVE)
        else report_value("active pixels per line", x_pos, H_ACTIVE);
        x_pos = 0;
        y_pos++;
      end
      prev_blank = o_video.blank;
      prev_hs = o_video.hsync;
      prev_vs = o_video.vsync;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_cpu);
    #1;
  endtask

  // mode 0 msb first with miso sampled just before the rising sck
  task automatic spi_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i > 7 - nbits; i--)
    begin
      i_mosi = tx[i];
      wait_cycles(SPI_HALF);
      rx[i] = o_miso;
      i_sclk = 1'b1;
      wait_cycles(SPI_HALF);
      i_sclk = 1'b0;
    end
  endtask

  task automatic spi_begin(input spi_data_t cmd, input spi_addr_t addr);
    logic [7:0] rx;
    wait_cycles(1);
    i_csn = 1'b0;
    wait_cycles(SPI_HALF);
    spi_bits(cmd, 8, rx);
    for (int i = 3; i >= 0; i--)
      spi_bits(addr[i * 8 +: 8], 8, rx);
  endtask

  task automatic spi_end();
    wait_cycles(SPI_HALF);
    i_csn = 1'b1;
    wait_cycles(SPI_HALF);
  endtask

  task automatic spi_write(input spi_addr_t addr, input int n);
    logic [7:0] rx;
    spi_addr_t  a;
    spi_begin(CMD_WRITE, addr);
    for (int i = 0; i < n; i++)
    begin
      spi_bits(xfer_buf[i], 8, rx);
      a = addr + i;
      if (a[31:24] == REGION_RAM)
        ram_shadow[a[3:0]] = xfer_buf[i];
      else if (a[31:24] == REGION_CHARS && int'(a[23:0]) < N_CHARS)
        char_shadow[int'(a[23:0])] = xfer_buf[i];
      else if (a[31:24] == REGION_CTRL)
        en_shadow = xfer_buf[i][0];
    end
    spi_end();
  endtask

  task automatic spi_read(input spi_addr_t addr, input int n);
    logic [7:0] rx;
    spi_addr_t  a;
    spi_begin(CMD_READ, addr);
    spi_bits(8'h00, 8, rx);  // dummy byte
    for (int i = 0; i < n; i++)
    begin
      spi_bits(8'h00, 8, rx);
      a = addr + i;
      assert (rx == ram_shadow[a[3:0]])
      else report_value($sformatf("o_miso byte at 0x%h", a), rx, ram_shadow[a[3:0]]);
    end
    spi_end();
  endtask

  // checks one whole frame from vsync to vsync
  task automatic check_frame();
    int start;
    start = frame_cnt;
    wait (frame_cnt == start + 1);
    pix_check = 1'b1;
    wait (frame_cnt == start + 2);
    pix_check = 1'b0;
  endtask

  initial
  begin
    logic [7:0] b;
    logic [7:0] rx;
    int base;
    i_rst_n = 1'b0;
    i_csn = 1'b1;
    i_sclk = 1'b0;
    i_mosi = 1'b0;
    pix_check = 1'b0;
    lfsr = 8'd94;
    en_shadow = 1'b1;
    for (int i = 0; i < N_CHARS; i++)
      char_shadow[i] = 8'h00;
    $readmemh("font.mem", font_rom);
    repeat (5) @(posedge clk_cpu);
    #1 i_rst_n = 1'b1;

    base = errors;
    wait (frame_cnt >= 2);
    finish_test("video timing", base);

    base = errors;
    check_frame();
    finish_test("test picture", base);

    base = errors;
    for (int i = 0; i < 16; i++)
      rand_byte(xfer_buf[i]);
    spi_write(32'h0000_0000, 16);
    spi_read(32'h0000_0000, 16);
    finish_test("scratch ram burst", base);

    base = errors;
    for (int i = 0; i < N_CHARS; i++)
      rand_byte(xfer_buf[i]);
    spi_write({REGION_CHARS, 24'h0}, N_CHARS);
    set_hits = 0;
    check_frame();
    assert (set_hits > 0)
    else
    begin
      $display("no lit glyph pixel was seen in the text window");
      errors++;
    end
    finish_test("glyph overlay", base);

    base = errors;
    xfer_buf[0] = 8'h00;
    spi_write({REGION_CTRL, 24'h0}, 1);
    check_frame();
    xfer_buf[0] = 8'h01;
    spi_write({REGION_CTRL, 24'h0}, 1);
    set_hits = 0;
    check_frame();
    assert (set_hits > 0)
    else
    begin
      $display("text did not come back after enabling the overlay");
      errors++;
    end
    finish_test("overlay enable", base);

    base = errors;
    spi_begin(CMD_WRITE, 32'h0000_0005);
    rand_byte(b);
    spi_bits(b, 4, rx);  // half a byte before csn goes high
    spi_end();
    rand_byte(xfer_buf[0]);
    spi_write(32'h0000_0009, 1);
    spi_read(32'h0000_0005, 5);
    finish_test("aborted write", base);

    $display("tests 6, failed %0d, errors %0d, assertion failures %0d",
             tests_failed, errors, dut.u_checker.fail_cnt);
    if (tests_failed == 0 && errors == 0 && dut.u_checker.fail_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: font.mem
// four 8x8 glyphs, eight row bytes each, top row first
// bit 7 of a row byte is the leftmost pixel
3C
66
6E
76
66
66
3C
00
18
38
18
18
18
18
7E
00
AA
55
AA
55
AA
55
AA
55
FF
81
BD
A5
A5
BD
81
FF

// File: all.f
video_pkg.sv
spi_pkg.sv
spi_ram_slave.sv
scratch_ram.sv
vga_timing.sv
osd_overlay.sv
osd_top.sv
osd_checker.sv
tb_osd_top.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the osd testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_osd_top -f all.f -o sim_osd
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_osd)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
